// File: verilog/gpuPkg.sv
`default_nettype none

package gpuPkg;

    // raster timing, tiny for simulation
    localparam int hActive = 16;
    localparam int hFront  = 2;
    localparam int hSync   = 2;
    localparam int hBack   = 2;
    localparam int hTotal  = hActive + hFront + hSync + hBack;
    localparam int vActive = 8;
    localparam int vFront  = 1;
    localparam int vSync   = 1;
    localparam int vBack   = 1;
    localparam int vTotal  = vActive + vFront + vSync + vBack;
    // pixels per bank
    localparam int fbDepth = hActive * vActive;

    // register map, low 4 address bits
    localparam logic [3:0] regXPos     = 4'd0;
    localparam logic [3:0] regYPos     = 4'd1;
    localparam logic [3:0] regPixel    = 4'd2;
    localparam logic [3:0] regLen      = 4'd3;
    localparam logic [3:0] regEnable   = 4'd4;
    localparam logic [3:0] regBurst    = 4'd5;
    localparam logic [3:0] regVblank   = 4'd6;
    localparam logic [3:0] regBusy     = 4'd7;
    localparam logic [3:0] regPingPong = 4'd8;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  regAddr_t;
    typedef logic [3:0]  byteEn_t;
    typedef logic [15:0] coord_t;
    typedef logic [23:0] rgb_t;
    typedef logic [23:0] spanLen_t;
    typedef logic [6:0]  fbAddr_t;

    // span command, straight out of registers 0..3
    typedef struct packed {
        coord_t   xPos;
        coord_t   yPos;
        rgb_t     pixel;
        spanLen_t len;
    } spanCmd_t;

    typedef struct packed {
        logic    we;
        fbAddr_t addr;
        rgb_t    pixel;
    } fbWrite_t;

    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;
        rgb_t rgb;
    } videoOut_t;

    typedef enum logic {spanIdle, spanRun} spanState_t;

endpackage

`default_nettype wire

// File: verilog/gpuRegs.sv
`timescale 1ns/1ps
`default_nettype none

module gpuRegs import gpuPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire regAddr_t addrIn,
    input  wire regAddr_t addrOut,
    input  wire byteEn_t  sizeDecode,
    input  wire word_t    dataIn,
    output word_t         dataOut,
    input  wire logic     busy,
    input  wire logic     vblank,
    output spanCmd_t      cmd,
    output logic          drawStart,
    output logic          pingPong
);

    // sixteen words, only the low address nibble decodes
    word_t regs [16];
    // set once a start went out for the current enable level
    logic  startDone;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < 16; i++)
            begin
                regs[i] <= '0;
            end
            dataOut   <= '0;
            startDone <= 1'b0;
        end
        else
        begin
            // byte lanes written independently
            for (int b = 0; b < 4; b++)
            begin
                if (sizeDecode[b])
                begin
                    regs[addrIn[3:0]][b*8 +: 8] <= dataIn[b*8 +: 8];
                end
            end
            // status mirror, overrides any host write this cycle
            regs[regVblank] <= {31'b0, vblank};
            regs[regBusy]   <= {31'b0, busy};
            // readback of the value before this edge
            dataOut <= regs[addrOut[3:0]];
            // re-arm only once the host drops enable
            if (!regs[regEnable][0])
            begin
                startDone <= 1'b0;
            end
            else if (drawStart)
            begin
                startDone <= 1'b1;
            end
        end
    end

    // one pulse per enable assertion, held off while the writer is busy
    assign drawStart = regs[regEnable][0] & ~regs[regBusy][0] & ~startDone;

    // command fields as levels
    assign cmd = '{
        xPos:  regs[regXPos][15:0],
        yPos:  regs[regYPos][15:0],
        pixel: regs[regPixel][23:0],
        len:   regs[regLen][23:0]
    };

    // draw bank select, display takes the other one
    assign pingPong = regs[regPingPong][0];

endmodule

`default_nettype wire

// File: verilog/spanWriter.sv
`timescale 1ns/1ps
`default_nettype none

module spanWriter import gpuPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire spanCmd_t cmd,
    input  wire logic     drawStart,
    input  wire logic     pingPong,
    output logic          busy,
    output fbWrite_t      wr,
    output logic          wrBank
);

    spanState_t state;
    spanLen_t   remaining;
    // column and row sized for the 16x8 raster
    logic [3:0] col;
    logic [2:0] row;
    // clip flags, column one goes low once x passes the right edge
    logic       colOk;
    logic       rowOk;
    rgb_t       color;
    logic       bank;

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state     <= spanIdle;
            remaining <= '0;
            colOk     <= 1'b0;
            rowOk     <= 1'b0;
            bank      <= 1'b0;
        end
        else
        begin
            case (state)
                spanIdle:
                begin
                    if (drawStart)
                    begin
                        state     <= spanRun;
                        remaining <= cmd.len;
                        colOk     <= cmd.xPos < coord_t'(hActive);
                        rowOk     <= cmd.yPos < coord_t'(vActive);
                        // bank fixed for the whole span
                        bank      <= pingPong;
                    end
                end
                spanRun:
                begin
                    // len of 0 still spends one cycle here
                    if (remaining > spanLen_t'(1))
                    begin
                        remaining <= remaining - spanLen_t'(1);
                    end
                    else
                    begin
                        state     <= spanIdle;
                        remaining <= '0;
                    end
                    if (col == 4'hF)
                    begin
                        colOk <= 1'b0;
                    end
                end
                default:
                begin
                    state <= spanIdle;
                end
            endcase
        end
    end

    // payload path
    always_ff @(posedge clk)
    begin
        if (state == spanIdle && drawStart)
        begin
            col   <= cmd.xPos[3:0];
            row   <= cmd.yPos[2:0];
            color <= cmd.pixel;
        end
        else if (state == spanRun)
        begin
            col <= col + 4'd1;
        end
    end

    assign busy   = (state == spanRun);
    assign wrBank = bank;

    // one pixel per run cycle, clipped pixels still use their cycle
    assign wr = '{
        we:    busy && (remaining != '0) && colOk && rowOk,
        addr:  {row, col},
        pixel: color
    };

endmodule

`default_nettype wire

// File: verilog/frameBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module frameBuffer import gpuPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire fbWrite_t wr,
    input  wire logic     wrBank,
    input  wire logic     rdBank,
    input  wire fbAddr_t  rdAddr,
    output rgb_t          rdPixel
);

    // two banks of pixels
    rgb_t mem [2][fbDepth];
    // marks pixels written since reset
    logic [1:0][fbDepth-1:0] written;
    rgb_t rdRaw;
    logic rdValid;

    // storage and raw read, old data on a same-address collision
    always_ff @(posedge clk)
    begin
        if (wr.we)
        begin
            mem[wrBank][wr.addr] <= wr.pixel;
        end
        rdRaw <= mem[rdBank][rdAddr];
    end

    // valid bits, cleared by reset so the banks read as black
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            written <= '0;
            rdValid <= 1'b0;
        end
        else
        begin
            if (wr.we)
            begin
                written[wrBank][wr.addr] <= 1'b1;
            end
            rdValid <= written[rdBank][rdAddr];
        end
    end

    // unwritten pixels come out as zero
    assign rdPixel = rdValid ? rdRaw : '0;

endmodule

`default_nettype wire

// File: verilog/videoTiming.sv
`timescale 1ns/1ps
`default_nettype none

module videoTiming import gpuPkg::*;
(
    input  wire logic clk,
    input  wire logic rstn,
    output fbAddr_t   rdAddr,
    input  wire rgb_t rdPixel,
    output logic      vblank,
    output videoOut_t video
);

    coord_t hCnt;
    coord_t vCnt;
    logic   hsRaw;
    logic   vsRaw;
    logic   deRaw;
    // one stage to match the framebuffer read latency
    logic   hsDly;
    logic   vsDly;
    logic   deDly;

    // raster counters
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hCnt <= '0;
            vCnt <= '0;
        end
        else if (hCnt == coord_t'(hTotal - 1))
        begin
            hCnt <= '0;
            if (vCnt == coord_t'(vTotal - 1))
            begin
                vCnt <= '0;
            end
            else
            begin
                vCnt <= vCnt + coord_t'(1);
            end
        end
        else
        begin
            hCnt <= hCnt + coord_t'(1);
        end
    end

    // line is active, front porch, sync, back porch
    assign hsRaw = (hCnt >= coord_t'(hActive + hFront))
                && (hCnt < coord_t'(hActive + hFront + hSync));
    assign vsRaw = (vCnt >= coord_t'(vActive + vFront))
                && (vCnt < coord_t'(vActive + vFront + vSync));
    assign deRaw  = (hCnt < coord_t'(hActive)) && (vCnt < coord_t'(vActive));
    assign vblank = (vCnt >= coord_t'(vActive));

    // address is don't care outside the active area
    assign rdAddr = {vCnt[2:0], hCnt[3:0]};

    // sync delay, then output register alongside the pixel
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            hsDly <= 1'b0;
            vsDly <= 1'b0;
            deDly <= 1'b0;
            video <= '0;
        end
        else
        begin
            hsDly <= hsRaw;
            vsDly <= vsRaw;
            deDly <= deRaw;
            video <= '{
                hsync: hsDly,
                vsync: vsDly,
                de:    deDly,
                rgb:   deDly ? rdPixel : '0
            };
        end
    end

endmodule

`default_nettype wire

// File: verilog/gpuTop.sv
`timescale 1ns/1ps
`default_nettype none

module gpuTop import gpuPkg::*;
(
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire regAddr_t addrIn,
    input  wire regAddr_t addrOut,
    input  wire byteEn_t  sizeDecode,
    input  wire word_t    dataIn,
    output word_t         dataOut,
    output videoOut_t     video
);

    wire spanCmd_t cmd;
    wire logic     drawStart;
    wire logic     busy;
    wire logic     pingPong;
    wire fbWrite_t wr;
    wire logic     wrBank;
    // display reads the bank not being drawn
    wire logic     dispBank;
    wire fbAddr_t  rdAddr;
    wire rgb_t     rdPixel;
    wire logic     vblank;

    assign dispBank = ~pingPong;

    gpuRegs i_gpuRegs (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .busy       (busy),
        .vblank     (vblank),
        .cmd        (cmd),
        .drawStart  (drawStart),
        .pingPong   (pingPong)
    );

    spanWriter i_spanWriter (
        .clk       (clk),
        .rstn      (rstn),
        .cmd       (cmd),
        .drawStart (drawStart),
        .pingPong  (pingPong),
        .busy      (busy),
        .wr        (wr),
        .wrBank    (wrBank)
    );

    frameBuffer i_frameBuffer (
        .clk     (clk),
        .rstn    (rstn),
        .wr      (wr),
        .wrBank  (wrBank),
        .rdBank  (dispBank),
        .rdAddr  (rdAddr),
        .rdPixel (rdPixel)
    );

    videoTiming i_videoTiming (
        .clk     (clk),
        .rstn    (rstn),
        .rdAddr  (rdAddr),
        .rdPixel (rdPixel),
        .vblank  (vblank),
        .video   (video)
    );

endmodule

`default_nettype wire

// File: verif/gpuTb.sv
`timescale 1ns/1ps
`default_nettype none

module gpuTb
    import gpuPkg::*;
();

    localparam int clkPeriod   = 100;
    localparam int frameCycles = hTotal * vTotal;
    // per test cycle budgets, then three spare frames
    localparam int budgetCycles = (3 + 64 + 3 * frameCycles) + 240
                                + (300 + 3 * frameCycles) + (480 + 3 * frameCycles)
                                + (400 + 7 * frameCycles) + (4 * frameCycles)
                                + 3 * frameCycles;

    logic      clk;
    logic      rstn;
    regAddr_t  addrIn;
    regAddr_t  addrOut;
    byteEn_t   sizeDecode;
    word_t     dataIn;
    word_t     dataOut;
    videoOut_t video;

    // model state
    word_t       modelRegs [16];
    rgb_t        modelBank [2][fbDepth];
    logic [31:0] seed;
    int          errors;
    int          testsRun;
    int          testsFailed;

    gpuTop i_dut (
        .clk        (clk),
        .rstn       (rstn),
        .addrIn     (addrIn),
        .addrOut    (addrOut),
        .sizeDecode (sizeDecode),
        .dataIn     (dataIn),
        .dataOut    (dataOut),
        .video      (video)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(clkPeriod / 2) clk = ~clk;
        end
    end

    // lcg with the halves swapped so the low bits are the better ones
    function automatic word_t nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};
    endfunction

    // all tasks start and end just after a falling edge
    task automatic writeReg(input logic [3:0] idx, input byteEn_t be, input word_t data);
        word_t r;
        r = nextRand();
        // upper address bits do not decode
        addrIn     = {r[7:4], idx};
        sizeDecode = be;
        dataIn     = data;
        @(negedge clk);
        sizeDecode = '0;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
            begin
                modelRegs[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic readCheck(input logic [3:0] idx, input word_t exp);
        word_t r;
        r = nextRand();
        addrOut = {r[7:4], idx};
        @(negedge clk);
        if (dataOut !== exp)
        begin
            $display("FAIL dataOut reg %0d exp 0x%08h got 0x%08h", idx, exp, dataOut);
            errors++;
        end
    endtask

    task automatic waitVsync(input logic level);
        int cycles;
        cycles = 0;
        while (video.vsync !== level && cycles < 2 * frameCycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (video.vsync !== level)
        begin
            $display("vsync never went to %0d within two frames", level);
            errors++;
        end
    endtask

    task automatic waitDe();
        int cycles;
        cycles = 0;
        while (video.de !== 1'b1 && cycles < 2 * frameCycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (video.de !== 1'b1)
        begin
            $display("de never went high within two frames");
            errors++;
        end
    endtask

    // one whole frame with the pixel index counted from the end of vsync
    task automatic checkFrame(input int bank);
        int   count;
        int   cycles;
        int   linePos;
        logic expHs;
        waitVsync(1'b0);
        waitVsync(1'b1);
        waitVsync(1'b0);
        count   = 0;
        cycles  = 0;
        // first sample is the start of the back porch line
        linePos = 0;
        while (video.vsync !== 1'b1 && cycles < 2 * frameCycles)
        begin
            expHs = (linePos >= hActive + hFront) && (linePos < hActive + hFront + hSync);
            if (video.hsync !== expHs)
            begin
                $display("FAIL hsync line pos 0x%0h exp 0x%0h got 0x%0h",
                         linePos, expHs, video.hsync);
                errors++;
            end
            if (video.de === 1'b1)
            begin
                if (count < fbDepth && video.rgb !== modelBank[bank][count])
                begin
                    $display("FAIL rgb pixel 0x%02h exp 0x%06h got 0x%06h",
                             count, modelBank[bank][count], video.rgb);
                    errors++;
                end
                count++;
            end
            else if (video.rgb !== '0)
            begin
                $display("FAIL rgb blanking exp 0x000000 got 0x%06h", video.rgb);
                errors++;
            end
            @(negedge clk);
            cycles++;
            linePos = (linePos + 1) % hTotal;
        end
        if (count != fbDepth)
        begin
            $display("FAIL de count exp 0x%0h got 0x%0h", fbDepth, count);
            errors++;
        end
        // back porch, active and front porch lines between two sync pulses
        if (cycles != (vTotal - vSync) * hTotal)
        begin
            $display("FAIL vsync low cycles exp 0x%0h got 0x%0h",
                     (vTotal - vSync) * hTotal, cycles);
            errors++;
        end
    endtask

    // re-arm, load the command, raise enable and follow busy through register 7
    task automatic drawSpan(input int x, input int y, input int len, input rgb_t pix);
        int   cycles;
        int   ones;
        int   expBusy;
        logic bank;
        bank = modelRegs[regPingPong][0];
        writeReg(regEnable, 4'h1, 32'h0);
        writeReg(regXPos, 4'hF, word_t'(x));
        writeReg(regYPos, 4'hF, word_t'(y));
        writeReg(regPixel, 4'hF, word_t'(pix));
        writeReg(regLen, 4'hF, word_t'(len));
        addrOut = {4'h5, regBusy};
        writeReg(regEnable, 4'h1, 32'h1);
        cycles = 0;
        while (dataOut !== 32'h1 && cycles < 16)
        begin
            @(negedge clk);
            cycles++;
        end
        if (dataOut !== 32'h1)
        begin
            $display("span at x %0d y %0d never showed busy", x, y);
            errors++;
        end
        else
        begin
            ones = 0;
            while (dataOut === 32'h1 && ones < len + 16)
            begin
                ones++;
                @(negedge clk);
            end
            expBusy = (len == 0) ? 1 : len;
            if (ones != expBusy)
            begin
                $display("FAIL busy cycles exp 0x%0h got 0x%0h", expBusy, ones);
                errors++;
            end
            if (dataOut !== 32'h0)
            begin
                $display("FAIL dataOut reg 7 exp 0x00000000 got 0x%08h", dataOut);
                errors++;
            end
        end
        // clipped pixels keep their cycle but write nothing
        for (int i = 0; i < len; i++)
        begin
            if (x + i < hActive && y < vActive)
            begin
                modelBank[bank][y * hActive + x + i] = pix;
            end
        end
    endtask

    // mostly crossing the right edge, some rows below the raster
    task automatic drawRandomSpans(input int n);
        int   x;
        int   y;
        int   len;
        rgb_t pix;
        for (int k = 0; k < n; k++)
        begin
            x   = 8 + int'(nextRand() % 12);
            y   = int'(nextRand() % 11);
            len = 2 + int'(nextRand() % 12);
            pix = nextRand();
            drawSpan(x, y, len, pix);
        end
    endtask

    task automatic finishTest(input string name, input int mark);
        testsRun++;
        if (errors == mark)
        begin
            $display("PASS %s", name);
        end
        else
        begin
            $display("FAIL %s with %0d errors", name, errors - mark);
            testsFailed++;
        end
    endtask

    // watchdog
    initial
    begin
        #(budgetCycles * clkPeriod);
        $display("timeout, run did not finish within %0d cycles", budgetCycles);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        word_t       r;
        word_t       data;
        logic [3:0]  idx;
        logic [3:0]  other;
        byteEn_t     be;
        int          mark;
        seed        = 32'h4749;
        errors      = 0;
        testsRun    = 0;
        testsFailed = 0;
        rstn        = 1'b0;
        addrIn      = '0;
        addrOut     = '0;
        sizeDecode  = '0;
        dataIn      = '0;
        for (int i = 0; i < 16; i++)
        begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < fbDepth; i++)
        begin
            modelBank[0][i] = '0;
            modelBank[1][i] = '0;
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // reset values, then a black frame
        mark = errors;
        for (int i = 0; i < 16; i++)
        begin
            readCheck(4'(i), 32'h0);
        end
        checkFrame(1);
        finishTest("reset state", mark);

        // byte lane writes to every register but the status ones
        mark = errors;
        for (int n = 0; n < 40; n++)
        begin
            r     = nextRand();
            idx   = r[3:0];
            other = r[7:4];
            if (idx == regVblank || idx == regBusy)
            begin
                idx = idx + 4'd4;
            end
            if (other == regVblank || other == regBusy)
            begin
                other = other + 4'd4;
            end
            be   = r[11:8];
            data = nextRand();
            // enable bit kept low so no span starts
            if (idx == regEnable)
            begin
                data[0] = 1'b0;
            end
            writeReg(idx, be, data);
            readCheck(idx, modelRegs[idx]);
            readCheck(other, modelRegs[other]);
        end
        finishTest("register byte writes", mark);

        // one start per enable assertion
        mark = errors;
        writeReg(regPingPong, 4'hF, 32'h0);
        drawSpan(3, 2, 5, 24'hA1B2C3);
        writeReg(regLen, 4'hF, 32'd9);
        writeReg(regEnable, 4'h1, 32'h3);
        addrOut = {4'h2, regBusy};
        repeat (40)
        begin
            @(negedge clk);
            if (dataOut !== 32'h0)
            begin
                $display("FAIL dataOut reg 7 exp 0x00000000 got 0x%08h", dataOut);
                errors++;
            end
        end
        writeReg(regPingPong, 4'hF, 32'h1);
        checkFrame(0);
        finishTest("enable start latch", mark);

        // clipped spans into bank 1, then shown
        mark = errors;
        drawRandomSpans(6);
        writeReg(regPingPong, 4'hF, 32'h0);
        checkFrame(1);
        finishTest("span clipping", mark);

        // drawing bank 0 while bank 1 is on screen
        mark = errors;
        fork
            begin
                // spans go out while the first checked frame is scanned
                waitVsync(1'b0);
                waitVsync(1'b1);
                waitVsync(1'b0);
                drawRandomSpans(5);
            end
            begin
                checkFrame(1);
                checkFrame(1);
            end
        join
        writeReg(regPingPong, 4'hF, 32'h1);
        checkFrame(0);
        finishTest("ping-pong isolation", mark);

        // vblank status trails the raster by two cycles
        mark = errors;
        addrOut = {4'h3, regVblank};
        repeat (3)
        begin
            waitVsync(1'b0);
            waitVsync(1'b1);
            if (dataOut !== 32'h1)
            begin
                $display("FAIL dataOut reg 6 exp 0x00000001 got 0x%08h", dataOut);
                errors++;
            end
            waitDe();
            repeat (4) @(negedge clk);
            if (dataOut !== 32'h0)
            begin
                $display("FAIL dataOut reg 6 exp 0x00000000 got 0x%08h", dataOut);
                errors++;
            end
        end
        finishTest("vblank status", mark);

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
        if (errors == 0 && testsFailed == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
verilog/gpuPkg.sv
verilog/gpuRegs.sv
verilog/spanWriter.sv
verilog/frameBuffer.sv
verilog/videoTiming.sv
verilog/gpuTop.sv
verif/gpuTb.sv

// File: Bender.yml
package:
  name: gpu_pixel_engine

sources:
  - files:
      - verilog/gpuPkg.sv
      - verilog/gpuRegs.sv
      - verilog/spanWriter.sv
      - verilog/frameBuffer.sv
      - verilog/videoTiming.sv
      - verilog/gpuTop.sv
  - target: test
    files:
      - verif/gpuTb.sv
